/* Bender.yml */
package:
  name: ahb_apb_bridge

sources:
  - files:
      - logic/ahbPkg.sv
      - logic/apbPkg.sv
      - logic/ahbCapture.sv
      - logic/bridgeFsm.sv
      - logic/apbDriver.sv
      - logic/readSteer.sv
      - logic/ahbApbBridge.sv
  - target: test
    files:
      - test/apbSlaveMem.sv
      - test/bridgeTb.sv

/* all.f */
logic/ahbPkg.sv
logic/apbPkg.sv
logic/ahbCapture.sv
logic/bridgeFsm.sv
logic/apbDriver.sv
logic/readSteer.sv
logic/ahbApbBridge.sv
test/apbSlaveMem.sv
test/bridgeTb.sv

/* logic/ahbApbBridge.sv */
`timescale 1ns/100ps
`default_nettype none

module ahbApbBridge
(
	input wire Hclk,
	input wire Hresetn,
	input wire Hsel,
	input wire ahbPkg::addrT Haddr,
	input wire ahbPkg::transT Htrans,
	input wire Hwrite,
	input wire ahbPkg::sizeT Hsize,
	input wire ahbPkg::dataT Hwdata,
	output logic Hreadyout,
	output ahbPkg::dataT Hrdata,
	output apbPkg::selT Pselx,
	output ahbPkg::addrT Paddr,
	output logic Penable,
	output logic Pwrite,
	output ahbPkg::dataT Pwdata,
	input wire ahbPkg::dataT Prdata
);

	logic valid;
	logic pendWrite;
	ahbPkg::addrT pendAddr;
	ahbPkg::sizeT pendSize;
	ahbPkg::dataT pendData;
	apbPkg::stateT state;
	logic apbLoad;
	logic advance;
	logic readDone;

	ahbCapture capture_i
	(
		.Hclk(Hclk), .Hresetn(Hresetn), .Hsel(Hsel), .Haddr(Haddr),
		.Htrans(Htrans), .Hwrite(Hwrite), .Hsize(Hsize), .Hwdata(Hwdata),
		.Hreadyout(Hreadyout), .advance(advance), .valid(valid),
		.pendWrite(pendWrite), .pendAddr(pendAddr), .pendSize(pendSize),
		.pendData(pendData)
	);

	bridgeFsm fsm_i
	(
		.Hclk(Hclk), .Hresetn(Hresetn), .valid(valid), .pendWrite(pendWrite),
		.Hreadyout(Hreadyout), .Penable(Penable), .Pwrite(Pwrite), .state(state),
		.apbLoad(apbLoad), .advance(advance), .readDone(readDone)
	);

	apbDriver driver_i
	(
		.Hclk(Hclk), .Hresetn(Hresetn), .state(state), .apbLoad(apbLoad),
		.pendAddr(pendAddr), .pendSize(pendSize), .pendData(pendData),
		.Pselx(Pselx), .Paddr(Paddr), .Pwdata(Pwdata)
	);

	readSteer steer_i
	(
		.Hclk(Hclk), .Hresetn(Hresetn), .readDone(readDone), .Prdata(Prdata),
		.Paddr(Paddr), .Pselx(Pselx), .pendSize(pendSize), .Hrdata(Hrdata)
	);

endmodule

`default_nettype wire

/* logic/ahbCapture.sv */
`timescale 1ns/100ps
`default_nettype none

module ahbCapture
(
	input wire Hclk,
	input wire Hresetn,
	input wire Hsel,
	input wire ahbPkg::addrT Haddr,
	input wire ahbPkg::transT Htrans,
	input wire Hwrite,
	input wire ahbPkg::sizeT Hsize,
	input wire ahbPkg::dataT Hwdata,
	input wire Hreadyout,
	input wire advance,
	output logic valid,
	output logic pendWrite,
	output ahbPkg::addrT pendAddr,
	output ahbPkg::sizeT pendSize,
	output ahbPkg::dataT pendData
);

	ahbPkg::addrT addr1;
	ahbPkg::sizeT size1;
	logic write0;
	logic write1;
	logic [1:0] count; // Entries held, 0 to 2
	logic dataPhase; // Write data phase open

	assign valid = Hsel && Hreadyout &&
		((Htrans == ahbPkg::transNonseq) || (Htrans == ahbPkg::transSeq));

	// Empty queue means the controller looks at the bus directly
	assign pendWrite = (count == 2'd0) ? Hwrite : write0;

	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
		begin
			count <= 2'd0;
			write0 <= 1'b0;
			write1 <= 1'b0;
		end
		else
		begin
			if (advance && !valid)
			begin
				write0 <= write1;
				count <= count - 2'd1;
			end
			else if (valid && !advance)
			begin
				if (count == 2'd0)
					write0 <= Hwrite;
				else
					write1 <= Hwrite;
				count <= count + 2'd1;
			end
			else if (valid && advance)
			begin
				if (count == 2'd1)
					write0 <= Hwrite;
				else
				begin
					write0 <= write1;
					write1 <= Hwrite;
				end
			end
		end
	end

	// Address and size payload, same queue movement
	always_ff @(posedge Hclk)
	begin
		if (advance && (count == 2'd2))
		begin
			pendAddr <= addr1;
			pendSize <= size1;
		end
		if (valid)
		begin
			if ((count == 2'd0) || (advance && (count == 2'd1)))
			begin
				pendAddr <= Haddr;
				pendSize <= Hsize;
			end
			else
			begin
				addr1 <= Haddr;
				size1 <= Hsize;
			end
		end
	end

	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
			dataPhase <= 1'b0;
		else if (valid)
			dataPhase <= Hwrite;
		else if (Hreadyout)
			dataPhase <= 1'b0; // Data phase done
	end

	always_ff @(posedge Hclk)
	begin
		if (dataPhase && Hreadyout)
			pendData <= Hwdata;
	end

endmodule

`default_nettype wire

/* logic/ahbPkg.sv */
`default_nettype none

package ahbPkg;

	localparam int addrWidth = 32;
	localparam int dataWidth = 32;

	typedef logic [addrWidth-1:0] addrT;
	typedef logic [dataWidth-1:0] dataT;
	typedef logic [1:0] transT;
	typedef logic [2:0] sizeT;
	typedef logic [1:0] laneT; // Byte offset in a word

	localparam transT transIdle = 2'b00;
	localparam transT transBusy = 2'b01;
	localparam transT transNonseq = 2'b10;
	localparam transT transSeq = 2'b11;

	localparam sizeT sizeByte = 3'b000;
	localparam sizeT sizeHalf = 3'b001;
	localparam sizeT sizeWord = 3'b010;

	// Little-endian lane pick, moved down to bit 0
	function automatic dataT laneExtract(dataT data, sizeT size, laneT lane);
		dataT res;
		res = '0;
		case (size)
			sizeByte: res = {24'b0, data[{lane, 3'b000} +: 8]};
			sizeHalf: if (!lane[0]) res = {16'b0, data[{lane, 3'b000} +: 16]};
			sizeWord: if (lane == 2'b00) res = data;
			default: res = '0; // Wider than the bus
		endcase
		return res;
	endfunction

endpackage

`default_nettype wire

/* logic/apbDriver.sv */
`timescale 1ns/100ps
`default_nettype none

module apbDriver
(
	input wire Hclk,
	input wire Hresetn,
	input wire apbPkg::stateT state,
	input wire apbLoad,
	input wire ahbPkg::addrT pendAddr,
	input wire ahbPkg::sizeT pendSize,
	input wire ahbPkg::dataT pendData,
	output apbPkg::selT Pselx,
	output ahbPkg::addrT Paddr,
	output ahbPkg::dataT Pwdata
);

	logic inWindow;
	logic [apbPkg::slaveIdxWidth-1:0] slaveIdx;
	logic writeLoad;

	assign inWindow = (pendAddr[ahbPkg::addrWidth-1:apbPkg::windowLsb] == apbPkg::windowBase);
	assign slaveIdx = pendAddr[apbPkg::slaveField +: apbPkg::slaveIdxWidth];
	assign writeLoad = apbLoad &&
		((state == apbPkg::stWrite) || (state == apbPkg::stWriteP));

	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
			Pselx <= '0;
		else if (apbLoad)
		begin
			if (inWindow)
				Pselx <= apbPkg::selT'(1) << slaveIdx;
			else
				Pselx <= '0; // Outside the window, cycle runs unselected
		end
		else if ((state == apbPkg::stIdle) || (state == apbPkg::stWwait))
			Pselx <= '0;
	end

	always_ff @(posedge Hclk)
	begin
		if (apbLoad)
			Paddr <= pendAddr;
		if (writeLoad)
			Pwdata <= ahbPkg::laneExtract(pendData, pendSize, ahbPkg::laneT'(pendAddr[1:0]));
	end

endmodule

`default_nettype wire

/* logic/apbPkg.sv */
`default_nettype none

package apbPkg;

	localparam int slaveCount = 4;

	typedef logic [slaveCount-1:0] selT;

	// Bridge window sits in address bits 31..14
	localparam int windowLsb = 14;
	localparam logic [17:0] windowBase = 18'h00010;

	// Slave index in bits 13..12
	localparam int slaveField = 12;
	localparam int slaveIdxWidth = 2;

	typedef enum logic [2:0]
	{
		stIdle,
		stRead,
		stRenable,
		stWwait,
		stWrite,
		stWenable,
		stWriteP,
		stWenableP
	} stateT;

endpackage

`default_nettype wire

/* logic/bridgeFsm.sv */
`timescale 1ns/100ps
`default_nettype none

module bridgeFsm
(
	input wire Hclk,
	input wire Hresetn,
	input wire valid,
	input wire pendWrite,
	output logic Hreadyout,
	output logic Penable,
	output logic Pwrite,
	output apbPkg::stateT state,
	output logic apbLoad,
	output logic advance,
	output logic readDone
);

	apbPkg::stateT nextState;
	logic readyNext;

	// APB outputs trail the state by one cycle
	always_comb
	begin
		nextState = state;
		readyNext = 1'b1;
		case (state)
			apbPkg::stIdle:
			begin
				if (valid && pendWrite)
					nextState = apbPkg::stWwait;
				else if (valid)
				begin
					nextState = apbPkg::stRead;
					readyNext = 1'b0;
				end
			end
			apbPkg::stRead:
			begin
				nextState = apbPkg::stRenable;
				readyNext = 1'b0;
			end
			apbPkg::stRenable:
			begin
				nextState = apbPkg::stIdle; // Enable cycle, Hrdata lands after it
				readyNext = 1'b0;
			end
			apbPkg::stWwait:
			begin
				readyNext = 1'b0;
				if (valid)
					nextState = apbPkg::stWriteP; // Second transfer waits in the queue
				else
					nextState = apbPkg::stWrite;
			end
			apbPkg::stWrite:
			begin
				nextState = apbPkg::stWenable;
			end
			apbPkg::stWenable:
			begin
				if (valid && pendWrite)
					nextState = apbPkg::stWwait;
				else if (valid)
				begin
					nextState = apbPkg::stRead;
					readyNext = 1'b0;
				end
				else
					nextState = apbPkg::stIdle;
			end
			apbPkg::stWriteP:
			begin
				nextState = apbPkg::stWenableP;
				readyNext = 1'b0;
			end
			apbPkg::stWenableP:
			begin
				if (pendWrite)
					nextState = apbPkg::stWwait; // Opens its stalled data phase
				else
				begin
					nextState = apbPkg::stRead;
					readyNext = 1'b0;
				end
			end
			default:
			begin
				nextState = apbPkg::stIdle;
			end
		endcase
	end

	assign apbLoad = (state == apbPkg::stRead) || (state == apbPkg::stWrite) ||
		(state == apbPkg::stWriteP);

	// Writes leave the queue at load, reads once data is taken
	assign advance = (state == apbPkg::stWrite) || (state == apbPkg::stWriteP) || readDone;

	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
		begin
			state <= apbPkg::stIdle;
			Hreadyout <= 1'b1;
			Penable <= 1'b0;
			Pwrite <= 1'b0;
			readDone <= 1'b0;
		end
		else
		begin
			state <= nextState;
			Hreadyout <= readyNext;
			readDone <= (state == apbPkg::stRenable);
			Penable <= (state == apbPkg::stRenable) || (state == apbPkg::stWenable) ||
				(state == apbPkg::stWenableP);
			case (state)
				apbPkg::stWrite, apbPkg::stWriteP: Pwrite <= 1'b1;
				apbPkg::stRenable, apbPkg::stWenable, apbPkg::stWenableP: Pwrite <= Pwrite;
				default: Pwrite <= 1'b0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/readSteer.sv */
`timescale 1ns/100ps
`default_nettype none

module readSteer
(
	input wire Hclk,
	input wire Hresetn,
	input wire readDone,
	input wire ahbPkg::dataT Prdata,
	input wire ahbPkg::addrT Paddr,
	input wire apbPkg::selT Pselx,
	input wire ahbPkg::sizeT pendSize,
	output ahbPkg::dataT Hrdata
);

	ahbPkg::dataT lane;

	// No slave selected reads as zero
	assign lane = (Pselx == '0) ? '0 :
		ahbPkg::laneExtract(Prdata, pendSize, ahbPkg::laneT'(Paddr[1:0]));

	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
			Hrdata <= '0;
		else if (readDone)
			Hrdata <= lane; // Held until the next read
	end

endmodule

`default_nettype wire

/* test/apbSlaveMem.sv */
`timescale 1ns/100ps
`default_nettype none

module apbSlaveMem
(
	input wire Hclk,
	input wire apbPkg::selT Pselx,
	input wire ahbPkg::addrT Paddr,
	input wire Penable,
	input wire Pwrite,
	input wire ahbPkg::dataT Pwdata,
	output ahbPkg::dataT Prdata
);

	localparam int words = 4096; // Four peripherals of 1024 words

	ahbPkg::dataT mem [0:words-1];
	logic [11:0] idx;

	assign idx = Paddr[13:2];

	initial
	begin
		int i;
		for (i = 0; i < words; i++)
			mem[i] = {i[11:0], 4'hC, ~i[11:0], 4'h3}; // Pattern from the whole index
	end

	// Word stored as it arrives, taken in the enable cycle
	always @(posedge Hclk)
	begin
		if ((Pselx != '0) && Penable && Pwrite)
			mem[idx] <= Pwdata;
	end

	assign Prdata = mem[idx] << {Paddr[1:0], 3'b000}; // Back up to the addressed lane

endmodule

`default_nettype wire

/* test/bridgeTb.sv */
`timescale 1ns/100ps
`default_nettype none

module bridgeTb;

	localparam int clkPeriod = 8;
	localparam int numTransfers = 400;

	typedef struct packed
	{
		logic write;
		ahbPkg::addrT addr;
		apbPkg::selT sel;
		ahbPkg::dataT data;
	} apbExpT;

	logic Hclk;
	logic Hresetn;
	logic Hsel;
	ahbPkg::addrT Haddr;
	ahbPkg::transT Htrans;
	logic Hwrite;
	ahbPkg::sizeT Hsize;
	ahbPkg::dataT Hwdata;
	logic Hreadyout;
	ahbPkg::dataT Hrdata;
	apbPkg::selT Pselx;
	ahbPkg::addrT Paddr;
	logic Penable;
	logic Pwrite;
	ahbPkg::dataT Pwdata;
	ahbPkg::dataT Prdata;

	integer seed = 32'h6400;
	apbExpT expQueue [$]; // APB transfers still to come in issue order
	ahbPkg::dataT modelMem [0:4095];
	int issued;
	int apbCount;
	logic lastRead;
	ahbPkg::dataT lastReadExp;
	ahbPkg::addrT lastAddr;

	ahbApbBridge dut_i
	(
		.Hclk(Hclk), .Hresetn(Hresetn), .Hsel(Hsel), .Haddr(Haddr), .Htrans(Htrans),
		.Hwrite(Hwrite), .Hsize(Hsize), .Hwdata(Hwdata), .Hreadyout(Hreadyout),
		.Hrdata(Hrdata), .Pselx(Pselx), .Paddr(Paddr), .Penable(Penable),
		.Pwrite(Pwrite), .Pwdata(Pwdata), .Prdata(Prdata)
	);

	apbSlaveMem mem_i
	(
		.Hclk(Hclk), .Pselx(Pselx), .Paddr(Paddr), .Penable(Penable),
		.Pwrite(Pwrite), .Pwdata(Pwdata), .Prdata(Prdata)
	);

	initial
	begin
		Hclk = 1'b0;
		forever #(clkPeriod / 2) Hclk = ~Hclk;
	end

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("ERROR %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
			$display("Simulation failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// Addressed lane moved down to bit 0
	function automatic ahbPkg::dataT laneDown(ahbPkg::dataT data, ahbPkg::sizeT size,
		logic [1:0] lane);
		ahbPkg::dataT shifted;
		shifted = data >> (8 * lane);
		if (size == ahbPkg::sizeByte)
			return shifted & 32'h0000_00FF;
		else if ((size == ahbPkg::sizeHalf) && !lane[0])
			return shifted & 32'h0000_FFFF;
		else if ((size == ahbPkg::sizeWord) && (lane == 2'd0))
			return shifted;
		return '0; // Unaligned or wider than the bus
	endfunction

	function automatic ahbPkg::dataT fillWord(logic [11:0] idx);
		return {idx, 4'hC, ~idx, 4'h3};
	endfunction

	task automatic checkResetState(input string when);
		checkValue(Hreadyout, 1'b1, {"Hreadyout ", when});
		checkValue(Penable, 1'b0, {"Penable ", when});
		checkValue(Pwrite, 1'b0, {"Pwrite ", when});
		checkValue(Pselx, '0, {"Pselx ", when});
	endtask

	// Edge that takes the driven address and ends the open data phase
	task automatic finishPhase();
		do
			@(posedge Hclk);
		while (Hreadyout !== 1'b1);
		if (lastRead)
			checkValue(Hrdata, lastReadExp, $sformatf("Hrdata for read at %h", lastAddr));
	endtask

	task automatic runIdle();
		logic [31:0] r;
		r = $random(seed);
		Hsel <= r[0];
		Htrans <= r[0] ? {1'b0, r[1]} : r[2:1]; // IDLE or BUSY while selected
		Haddr <= $random(seed);
		Hwrite <= r[3];
		finishPhase();
		Hwdata <= $random(seed);
		lastRead = 1'b0;
	endtask

	task automatic runTransfer(input logic write, input ahbPkg::addrT addr,
		input ahbPkg::sizeT size, input ahbPkg::dataT data);
		apbExpT entry;
		logic inWin;
		logic [11:0] idx;
		Hsel <= 1'b1;
		Htrans <= ($random(seed) & 1) ? ahbPkg::transSeq : ahbPkg::transNonseq;
		Haddr <= addr;
		Hwrite <= write;
		Hsize <= size;
		finishPhase();
		inWin = (addr[31:apbPkg::windowLsb] == apbPkg::windowBase);
		idx = addr[13:2];
		entry.write = write;
		entry.addr = addr;
		entry.sel = '0;
		if (inWin)
			entry.sel[addr[apbPkg::slaveField +: 2]] = 1'b1;
		entry.data = write ? laneDown(data, size, addr[1:0]) : '0;
		expQueue.push_back(entry);
		issued++;
		if (write && inWin)
			modelMem[idx] = entry.data;
		lastRead = !write;
		lastAddr = addr;
		// Slave moves the word up by the lane and the bridge takes it back down
		lastReadExp = inWin ? laneDown(modelMem[idx] << (8 * addr[1:0]), size, addr[1:0]) : '0;
		Hwdata <= write ? data : ahbPkg::dataT'($random(seed));
	endtask

	task automatic randomTransfer();
		logic [31:0] r;
		logic [31:0] a;
		ahbPkg::sizeT size;
		logic [1:0] lane;
		logic [17:0] upper;
		r = $random(seed);
		a = $random(seed);
		size = (r[3:0] == 4'd0) ? 3'b011 : ahbPkg::sizeT'(r[5:4] % 3);
		lane = r[7:6];
		if (r[10:8] != 3'd0)
		begin
			if (size == ahbPkg::sizeHalf)
				lane[0] = 1'b0;
			else if (size != ahbPkg::sizeByte)
				lane = 2'd0;
		end
		upper = apbPkg::windowBase;
		if (r[13:11] == 3'd0)
			upper = upper ^ (a[31:14] | 18'd1); // Outside the window
		runTransfer(r[16], {upper, a[1:0], 6'b0, a[5:2], lane}, size, $random(seed));
	endtask

	// APB protocol and transfer order
	initial
	begin
		apbExpT entry;
		logic prevPenable;
		logic prevPwrite;
		apbPkg::selT prevPselx;
		ahbPkg::addrT prevPaddr;
		ahbPkg::dataT prevPwdata;
		wait (Hresetn === 1'b1);
		forever
		begin
			@(posedge Hclk);
			checkValue($countones(Pselx) > 1, 1'b0, "Pselx has more than one bit set");
			if (Penable === 1'b1)
			begin
				checkValue(prevPenable, 1'b0, "Penable high without a setup cycle");
				checkValue(Paddr, prevPaddr, "Paddr moved in enable cycle");
				checkValue(Pwrite, prevPwrite, "Pwrite moved in enable cycle");
				checkValue(Pselx, prevPselx, "Pselx moved in enable cycle");
				if (Pwrite)
					checkValue(Pwdata, prevPwdata, "Pwdata moved in enable cycle");
				checkValue(expQueue.size() == 0, 1'b0, "APB transfer with no AHB transfer");
				entry = expQueue.pop_front();
				checkValue(Paddr, entry.addr, "Paddr");
				checkValue(Pwrite, entry.write, "Pwrite");
				checkValue(Pselx, entry.sel, "Pselx");
				if (entry.write)
					checkValue(Pwdata, entry.data, $sformatf("Pwdata at %h", entry.addr));
				apbCount++;
			end
			prevPenable = Penable;
			prevPwrite = Pwrite;
			prevPselx = Pselx;
			prevPaddr = Paddr;
			prevPwdata = Pwdata;
		end
	end

	initial
	begin
		#(numTransfers * 12 * clkPeriod);
		$display("Watchdog expired before all transfers finished");
		$display("Simulation failed");
		$fatal(1, "timeout");
	end

	initial
	begin
		int i;
		int drainCycles;
		Hresetn = 1'b0;
		Hsel = 1'b0;
		Haddr = '0;
		Htrans = ahbPkg::transIdle;
		Hwrite = 1'b0;
		Hsize = ahbPkg::sizeByte;
		Hwdata = '0;
		lastRead = 1'b0;
		issued = 0;
		apbCount = 0;
		for (i = 0; i < 4096; i++)
			modelMem[i] = fillWord(i[11:0]);
		repeat (3) @(posedge Hclk);
		checkResetState("during reset");
		@(posedge Hclk);
		Hresetn <= 1'b1;
		@(posedge Hclk);
		checkResetState("after reset");
		// Back-to-back writes to each slave and then read back
		for (i = 0; i < 4; i++)
			runTransfer(1'b1, {apbPkg::windowBase, 2'(i), 6'b0, 4'(i), 2'b00},
				ahbPkg::sizeWord, $random(seed));
		for (i = 0; i < 4; i++)
			runTransfer(1'b0, {apbPkg::windowBase, 2'(i), 6'b0, 4'(i), 2'b00},
				ahbPkg::sizeWord, '0);
		for (i = 8; i < numTransfers; i++)
		begin
			if (($random(seed) & 3) == 0)
				repeat (1 + (($random(seed) & 32'h7fff_ffff) % 3))
					runIdle();
			randomTransfer();
		end
		runIdle(); // Closes the last data phase
		Hsel <= 1'b0;
		Htrans <= ahbPkg::transIdle;
		drainCycles = 0;
		while ((expQueue.size() != 0) && (drainCycles < 32))
		begin
			@(posedge Hclk);
			drainCycles++;
		end
		repeat (4) @(posedge Hclk);
		if (expQueue.size() == 0)
		begin
			$display("Simulation passed");
			$finish;
		end
		else
		begin
			$display("APB ran %0d transfers for %0d AHB transfers", apbCount, issued);
			$display("Simulation failed");
			$fatal(1, "transfer count mismatch");
		end
	end

endmodule

`default_nettype wire
